//--- mem_test_pkg.sv
package mem_test_pkg;

  // widths of the SRAM pins and of the AXI side
  localparam int SRAM_ADDR_W = 20;
  localparam int SRAM_DATA_W = 16;
  localparam int AXI_ADDR_W = SRAM_ADDR_W + 1;

  typedef logic [SRAM_ADDR_W-1:0] sram_addr_t;
  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [SRAM_DATA_W-1:0] axi_data_t;
  typedef logic [7:0] burst_len_t;

  // the test region is eight bursts of three beats
  localparam int NUM_BURSTS = 8;
  localparam int NUM_BEATS = 3;
  localparam int BYTES_PER_BEAT = SRAM_DATA_W / 8;
  localparam int BYTES_PER_BURST = BYTES_PER_BEAT * NUM_BEATS;

  localparam axi_addr_t BURST_ADDR_BASE = axi_addr_t'(8'h0A);
  localparam axi_data_t BEAT_DATA_BASE = axi_data_t'(8'hD0);
  localparam burst_len_t BURST_LEN = burst_len_t'(NUM_BEATS - 1);

  typedef struct packed {
    axi_addr_t  addr;
    burst_len_t len;
  } axi_ax_t;

  typedef struct packed {
    axi_data_t data;
    logic      last;
  } axi_w_t;

  typedef struct packed {
    axi_data_t data;
    logic      last;
  } axi_r_t;

  // shared by the write sequencer and the read checker
  typedef enum logic [2:0] {
    idle,
    burst_init,
    burst,
    done,
    fail
  } test_state_t;

endpackage

//--- axi_sram_ctrl.sv
`timescale 1ns/10ps

module axi_sram_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,

  input  mem_test_pkg::axi_ax_t    aw,
  input  logic                     aw_valid,
  output logic                     aw_ready,

  input  mem_test_pkg::axi_w_t     w,
  input  logic                     w_valid,
  output logic                     w_ready,

  output logic                     b_valid,

  input  mem_test_pkg::axi_ax_t    ar,
  input  logic                     ar_valid,
  output logic                     ar_ready,

  output mem_test_pkg::axi_r_t     r,
  output logic                     r_valid,

  output mem_test_pkg::sram_addr_t sram_addr,
  output mem_test_pkg::axi_data_t  sram_dq_out,
  output logic                     sram_dq_oe,
  input  mem_test_pkg::axi_data_t  sram_dq_in,
  output logic                     sram_we_n,
  output logic                     sram_oe_n,
  output logic                     sram_ce_n
);

  typedef enum logic [2:0] {
    ctrl_idle,
    ctrl_wr_data,
    ctrl_wr_pin,
    ctrl_wr_resp,
    ctrl_rd_pin,
    ctrl_rd_data
  } ctrl_state_t;

  ctrl_state_t              state;

  mem_test_pkg::sram_addr_t word_addr;
  mem_test_pkg::burst_len_t beat_len;
  mem_test_pkg::burst_len_t beat_cnt;
  mem_test_pkg::axi_data_t  wr_data;
  logic                     wr_last;
  mem_test_pkg::axi_data_t  rd_data;

  logic                     aw_hs;
  logic                     ar_hs;
  logic                     w_hs;
  logic                     wr_end;
  logic                     rd_end;

  assign aw_hs  = aw_valid && aw_ready;
  assign ar_hs  = ar_valid && ar_ready;
  assign w_hs   = w_valid && w_ready;

  // a write burst also ends early if the master flags its last beat
  assign wr_end = (beat_cnt == beat_len) || wr_last;
  assign rd_end = beat_cnt == beat_len;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ctrl_idle;
    end else begin
      case (state)
        ctrl_idle: begin
          if (aw_hs) begin
            state <= ctrl_wr_data;
          end else if (ar_hs) begin
            state <= ctrl_rd_pin;
          end
        end

        ctrl_wr_data: begin
          if (w_hs) begin
            state <= ctrl_wr_pin;
          end
        end

        ctrl_wr_pin: begin
          state <= wr_end ? ctrl_wr_resp : ctrl_wr_data;
        end

        ctrl_wr_resp: begin
          state <= ctrl_idle;
        end

        ctrl_rd_pin: begin
          state <= ctrl_rd_data;
        end

        ctrl_rd_data: begin
          state <= rd_end ? ctrl_idle : ctrl_rd_pin;
        end

        default: begin
          state <= ctrl_idle;
        end
      endcase
    end
  end

  // burst address and beat tracking, plus the data holding registers
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      word_addr <= aw.addr[mem_test_pkg::AXI_ADDR_W-1:1];
      beat_len  <= aw.len;
      beat_cnt  <= '0;
    end else if (ar_hs) begin
      word_addr <= ar.addr[mem_test_pkg::AXI_ADDR_W-1:1];
      beat_len  <= ar.len;
      beat_cnt  <= '0;
    end else if ((state == ctrl_wr_pin && !wr_end) || (state == ctrl_rd_data && !rd_end)) begin
      word_addr <= word_addr + 1'b1;
      beat_cnt  <= beat_cnt + 1'b1;
    end

    if (w_hs) begin
      wr_data <= w.data;
      wr_last <= w.last;
    end

    // the SRAM output has settled by the end of the address cycle
    if (state == ctrl_rd_pin) begin
      rd_data <= sram_dq_in;
    end
  end

  assign aw_ready    = state == ctrl_idle;
  assign ar_ready    = (state == ctrl_idle) && !aw_valid;
  assign w_ready     = state == ctrl_wr_data;
  assign b_valid     = state == ctrl_wr_resp;
  assign r_valid     = state == ctrl_rd_data;
  assign r           = '{data: rd_data, last: rd_end};

  assign sram_addr   = word_addr;
  assign sram_dq_out = wr_data;
  assign sram_dq_oe  = state == ctrl_wr_pin;
  assign sram_we_n   = state != ctrl_wr_pin;
  assign sram_oe_n   = state != ctrl_rd_pin;
  assign sram_ce_n   = !(state == ctrl_wr_pin || state == ctrl_rd_pin);

endmodule

//--- mem_test_writer.sv
`timescale 1ns/10ps

module mem_test_writer (
  input  logic                  clk,
  input  logic                  rst_n,

  output mem_test_pkg::axi_ax_t aw,
  output logic                  aw_valid,
  input  logic                  aw_ready,

  output mem_test_pkg::axi_w_t  w,
  output logic                  w_valid,
  input  logic                  w_ready,

  input  logic                  b_valid,
  output logic                  write_done
);

  mem_test_pkg::test_state_t state;
  mem_test_pkg::test_state_t state_next;

  mem_test_pkg::axi_addr_t   burst_addr;
  mem_test_pkg::axi_addr_t   burst_addr_next;
  logic [7:0]                burst_cnt;
  logic [7:0]                burst_cnt_next;
  logic [7:0]                beat_cnt;
  logic [7:0]                beat_cnt_next;
  logic [7:0]                data_cnt;
  logic [7:0]                data_cnt_next;

  mem_test_pkg::axi_data_t   data_calc;
  mem_test_pkg::axi_ax_t     aw_next;
  mem_test_pkg::axi_w_t      w_next;
  logic                      aw_valid_next;
  logic                      w_valid_next;

  assign data_calc = mem_test_pkg::BEAT_DATA_BASE + mem_test_pkg::axi_data_t'(data_cnt);

  always_comb begin
    state_next      = state;
    burst_addr_next = burst_addr;
    burst_cnt_next  = burst_cnt;
    beat_cnt_next   = beat_cnt;
    data_cnt_next   = data_cnt;

    aw_valid_next   = aw_valid && !aw_ready;
    aw_next         = aw;
    w_valid_next    = w_valid && !w_ready;
    w_next          = w;

    case (state)
      mem_test_pkg::idle: begin
        state_next      = mem_test_pkg::burst_init;
        burst_addr_next = mem_test_pkg::BURST_ADDR_BASE;
        burst_cnt_next  = '0;
        beat_cnt_next   = '0;
        data_cnt_next   = '0;
      end

      mem_test_pkg::burst_init: begin
        // first beat goes out together with the burst address
        if (!aw_valid || aw_ready) begin
          state_next     = mem_test_pkg::burst;
          aw_valid_next  = 1'b1;
          aw_next        = '{addr: burst_addr, len: mem_test_pkg::BURST_LEN};
          burst_cnt_next = burst_cnt + 1'b1;
          beat_cnt_next  = beat_cnt + 1'b1;
          data_cnt_next  = data_cnt + 1'b1;
          w_valid_next   = 1'b1;
          w_next         = '{data: data_calc, last: beat_cnt_next == 8'(mem_test_pkg::NUM_BEATS)};
        end
      end

      mem_test_pkg::burst: begin
        if (w_valid && w_ready && beat_cnt != 8'(mem_test_pkg::NUM_BEATS)) begin
          beat_cnt_next = beat_cnt + 1'b1;
          data_cnt_next = data_cnt + 1'b1;
          w_valid_next  = 1'b1;
          w_next        = '{data: data_calc, last: beat_cnt_next == 8'(mem_test_pkg::NUM_BEATS)};
        end

        if (b_valid) begin
          if (burst_cnt != 8'(mem_test_pkg::NUM_BURSTS)) begin
            state_next      = mem_test_pkg::burst_init;
            beat_cnt_next   = '0;
            burst_addr_next = burst_addr + mem_test_pkg::axi_addr_t'(mem_test_pkg::BYTES_PER_BURST);
          end else begin
            state_next = mem_test_pkg::done;
          end
        end
      end

      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= mem_test_pkg::idle;
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
    end else begin
      state    <= state_next;
      aw_valid <= aw_valid_next;
      w_valid  <= w_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    burst_addr <= burst_addr_next;
    burst_cnt  <= burst_cnt_next;
    beat_cnt   <= beat_cnt_next;
    data_cnt   <= data_cnt_next;
    aw         <= aw_next;
    w          <= w_next;
  end

  assign write_done = state == mem_test_pkg::done;

endmodule

//--- mem_test_reader.sv
`timescale 1ns/10ps

module mem_test_reader (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    write_done,

  output mem_test_pkg::axi_ax_t   ar,
  output logic                    ar_valid,
  input  logic                    ar_ready,

  input  mem_test_pkg::axi_r_t    r,
  input  logic                    r_valid,

  output logic                    test_done,
  output logic                    test_pass,
  output mem_test_pkg::axi_data_t last_actual,
  output mem_test_pkg::axi_data_t last_expected,
  output logic [7:0]              pass_count
);

  mem_test_pkg::test_state_t state;
  mem_test_pkg::test_state_t state_next;

  mem_test_pkg::axi_addr_t   burst_addr;
  mem_test_pkg::axi_addr_t   burst_addr_next;
  logic [7:0]                burst_cnt;
  logic [7:0]                burst_cnt_next;
  logic [7:0]                data_cnt;
  logic [7:0]                data_cnt_next;

  mem_test_pkg::axi_data_t   data_calc;
  mem_test_pkg::axi_data_t   last_actual_next;
  mem_test_pkg::axi_data_t   last_expected_next;
  mem_test_pkg::axi_ax_t     ar_next;
  logic                      ar_valid_next;

  // expected value follows from the global beat index
  assign data_calc = mem_test_pkg::BEAT_DATA_BASE + mem_test_pkg::axi_data_t'(data_cnt);

  always_comb begin
    state_next         = state;
    burst_addr_next    = burst_addr;
    burst_cnt_next     = burst_cnt;
    data_cnt_next      = data_cnt;
    last_actual_next   = last_actual;
    last_expected_next = last_expected;
    ar_valid_next      = ar_valid && !ar_ready;
    ar_next            = ar;

    case (state)
      mem_test_pkg::idle: begin
        burst_addr_next = mem_test_pkg::BURST_ADDR_BASE;
        burst_cnt_next  = '0;
        data_cnt_next   = '0;
        if (write_done) begin
          state_next = mem_test_pkg::burst_init;
        end
      end

      mem_test_pkg::burst_init: begin
        if (!ar_valid || ar_ready) begin
          state_next     = mem_test_pkg::burst;
          ar_valid_next  = 1'b1;
          ar_next        = '{addr: burst_addr, len: mem_test_pkg::BURST_LEN};
          burst_cnt_next = burst_cnt + 1'b1;
        end
      end

      mem_test_pkg::burst: begin
        if (r_valid) begin
          data_cnt_next      = data_cnt + 1'b1;
          last_actual_next   = r.data;
          last_expected_next = data_calc;
          if (r.data != data_calc) begin
            state_next = mem_test_pkg::fail;
          end else if (r.last) begin
            if (burst_cnt != 8'(mem_test_pkg::NUM_BURSTS)) begin
              state_next      = mem_test_pkg::burst_init;
              burst_addr_next = burst_addr +
                                mem_test_pkg::axi_addr_t'(mem_test_pkg::BYTES_PER_BURST);
            end else begin
              state_next = mem_test_pkg::done;
            end
          end
        end
      end

      // one cycle here per clean pass, then the next pass starts
      mem_test_pkg::done: begin
        state_next = mem_test_pkg::idle;
      end

      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= mem_test_pkg::idle;
      ar_valid   <= 1'b0;
      pass_count <= '0;
    end else begin
      state    <= state_next;
      ar_valid <= ar_valid_next;
      if (state == mem_test_pkg::done) begin
        pass_count <= pass_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    burst_addr    <= burst_addr_next;
    burst_cnt     <= burst_cnt_next;
    data_cnt      <= data_cnt_next;
    last_actual   <= last_actual_next;
    last_expected <= last_expected_next;
    ar            <= ar_next;
  end

  assign test_done = state == mem_test_pkg::done;
  assign test_pass = state != mem_test_pkg::fail;

endmodule

//--- mem_test_top.sv
`timescale 1ns/10ps

module mem_test_top (
  input  logic                     clk,
  input  logic                     rst_n,

  output logic                     test_done,
  output logic                     test_pass,
  output logic [7:0]               debug0,
  output logic [7:0]               debug1,
  output logic [7:0]               debug2,

  output mem_test_pkg::sram_addr_t sram_addr,
  output mem_test_pkg::axi_data_t  sram_dq_out,
  output logic                     sram_dq_oe,
  input  mem_test_pkg::axi_data_t  sram_dq_in,
  output logic                     sram_we_n,
  output logic                     sram_oe_n,
  output logic                     sram_ce_n
);

  mem_test_pkg::axi_ax_t   aw;
  logic                    aw_valid;
  logic                    aw_ready;
  mem_test_pkg::axi_w_t    w;
  logic                    w_valid;
  logic                    w_ready;
  logic                    b_valid;
  mem_test_pkg::axi_ax_t   ar;
  logic                    ar_valid;
  logic                    ar_ready;
  mem_test_pkg::axi_r_t    r;
  logic                    r_valid;

  logic                    write_done;
  mem_test_pkg::axi_data_t last_actual;
  mem_test_pkg::axi_data_t last_expected;
  logic [7:0]              pass_count;

  mem_test_writer writer_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .aw        (aw),
    .aw_valid  (aw_valid),
    .aw_ready  (aw_ready),
    .w         (w),
    .w_valid   (w_valid),
    .w_ready   (w_ready),
    .b_valid   (b_valid),
    .write_done(write_done)
  );

  mem_test_reader reader_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .write_done   (write_done),
    .ar           (ar),
    .ar_valid     (ar_valid),
    .ar_ready     (ar_ready),
    .r            (r),
    .r_valid      (r_valid),
    .test_done    (test_done),
    .test_pass    (test_pass),
    .last_actual  (last_actual),
    .last_expected(last_expected),
    .pass_count   (pass_count)
  );

  axi_sram_ctrl ctrl_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .aw         (aw),
    .aw_valid   (aw_valid),
    .aw_ready   (aw_ready),
    .w          (w),
    .w_valid    (w_valid),
    .w_ready    (w_ready),
    .b_valid    (b_valid),
    .ar         (ar),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .r          (r),
    .r_valid    (r_valid),
    .sram_addr  (sram_addr),
    .sram_dq_out(sram_dq_out),
    .sram_dq_oe (sram_dq_oe),
    .sram_dq_in (sram_dq_in),
    .sram_we_n  (sram_we_n),
    .sram_oe_n  (sram_oe_n),
    .sram_ce_n  (sram_ce_n)
  );

  // low bytes are enough to see the pattern on the board LEDs
  assign debug0 = last_actual[7:0];
  assign debug1 = last_expected[7:0];
  assign debug2 = pass_count;

endmodule

//--- sram_model.sv
`timescale 1ns/10ps

module sram_model (
  input  mem_test_pkg::sram_addr_t addr,
  input  mem_test_pkg::axi_data_t  dq_out,
  input  logic                     dq_oe,
  output mem_test_pkg::axi_data_t  dq_in,
  input  logic                     ce_n,
  input  logic                     we_n,
  input  logic                     oe_n,
  input  logic                     fault_en,
  input  mem_test_pkg::sram_addr_t fault_addr
);

  mem_test_pkg::axi_data_t mem [0:(1 << mem_test_pkg::SRAM_ADDR_W) - 1];
  mem_test_pkg::axi_data_t read_word;

  // the cell follows the bus for as long as the write strobe is low
  always @* begin
    if (!ce_n && !we_n && dq_oe) begin
      mem[addr] = dq_out;
    end
  end

  // an inverted bit 0 at one word stands in for a broken cell
  always_comb begin
    read_word = mem[addr];
    if (fault_en && addr == fault_addr) begin
      read_word[0] = ~read_word[0];
    end
  end

  // the DUT drive wins on the split data bus and the SRAM drives during a read
  always_comb begin
    if (dq_oe) begin
      dq_in = dq_out;
    end else if (!ce_n && !oe_n) begin
      dq_in = read_word;
    end else begin
      dq_in = '0;
    end
  end

endmodule

//--- mem_test_monitor.sv
`timescale 1ns/10ps

module mem_test_monitor (
  input  logic                     clk,
  input  logic                     rst_n,
  input  mem_test_pkg::sram_addr_t sram_addr,
  input  mem_test_pkg::axi_data_t  sram_dq_out,
  input  logic                     sram_dq_oe,
  input  logic                     sram_we_n,
  input  logic                     sram_oe_n,
  input  logic                     sram_ce_n,
  input  logic                     test_done,
  input  logic                     test_pass,
  input  logic [7:0]               debug0,
  input  logic [7:0]               debug1,
  input  logic [7:0]               debug2,
  input  logic                     fault_en,
  input  int                       fault_beat,
  output int                       error_count,
  output int                       done_count
);

  localparam int TOTAL_BEATS = 24;

  typedef struct packed {
    mem_test_pkg::sram_addr_t addr;
    mem_test_pkg::axi_data_t  data;
  } beat_ref_t;

  int   write_count;
  logic reset_seen;
  logic done_prev;
  logic pass_prev;
  logic read_checked;

  // beat k of the pattern sits at word 5 + k and holds 0xD0 + k
  function automatic beat_ref_t reference_beat(input int k);
    beat_ref_t b;
    b.addr = mem_test_pkg::sram_addr_t'(5 + k);
    b.data = mem_test_pkg::axi_data_t'(32'hD0 + k);
    return b;
  endfunction

  task automatic compare_hex(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("MISMATCH %s: got 0x%0h expected 0x%0h at %0t", name, got, expected, $time);
      error_count = error_count + 1;
    end
  endtask

  task automatic report_failure(input string what);
    $display("ERROR: %s at %0t", what, $time);
    error_count = error_count + 1;
  endtask

  initial begin
    error_count  = 0;
    done_count   = 0;
    write_count  = 0;
    reset_seen   = 1'b0;
    done_prev    = 1'b0;
    pass_prev    = 1'b1;
    read_checked = 1'b0;
  end

  always @(posedge clk) begin
    beat_ref_t expected;
    if (!rst_n) begin
      reset_seen   = 1'b1;
      write_count  = 0;
      done_count   = 0;
      read_checked = 1'b0;
      done_prev    = 1'b0;
      pass_prev    = 1'b1;
    end else if (reset_seen) begin
      // nothing may move before the first write of the fill
      if (write_count == 0 && (sram_ce_n || sram_we_n)) begin
        compare_hex("test_done", test_done, 1'b0);
        compare_hex("test_pass", test_pass, 1'b1);
        compare_hex("sram_ce_n", sram_ce_n, 1'b1);
        compare_hex("sram_we_n", sram_we_n, 1'b1);
        compare_hex("sram_oe_n", sram_oe_n, 1'b1);
      end

      if (!sram_ce_n && !sram_we_n) begin
        if (write_count >= TOTAL_BEATS) begin
          report_failure("more than 24 SRAM write cycles after reset");
        end else begin
          expected = reference_beat(write_count);
          compare_hex("sram_addr", sram_addr, expected.addr);
          compare_hex("sram_dq_out", sram_dq_out, expected.data);
          compare_hex("sram_dq_oe", sram_dq_oe, 1'b1);
        end
        write_count = write_count + 1;
      end

      if (!sram_ce_n && !sram_oe_n && !read_checked) begin
        read_checked = 1'b1;
        if (write_count != TOTAL_BEATS) begin
          report_failure($sformatf("reads began after %0d SRAM write cycles instead of 24",
                                   write_count));
        end
      end

      // pass_count moves one cycle after the pulse
      compare_hex("debug2", debug2, done_count[7:0]);

      if (test_done) begin
        if (done_prev) begin
          report_failure("test_done stayed high for more than one cycle");
        end
        if (fault_en) begin
          report_failure("test_done pulsed although a fault was injected");
        end
        expected = reference_beat(TOTAL_BEATS - 1);
        compare_hex("debug0", debug0, expected.data[7:0]);
        compare_hex("debug1", debug1, expected.data[7:0]);
        done_count = done_count + 1;
      end

      if (pass_prev && !test_pass) begin
        if (!fault_en) begin
          report_failure("test_pass fell without an injected fault");
        end else begin
          expected = reference_beat(fault_beat);
          compare_hex("debug1", debug1, expected.data[7:0]);
          compare_hex("debug0", debug0, expected.data[7:0] ^ 8'h01);
        end
      end
      if (!pass_prev && test_pass) begin
        report_failure("test_pass rose again before a reset");
      end

      done_prev = test_done;
      pass_prev = test_pass;
    end
  end

endmodule

//--- tb_mem_test.sv
`timescale 1ns/10ps

module tb_mem_test;

  localparam int WRITE_CYCLES = 150;
  localparam int PASS_CYCLES = 80;
  localparam int RUN_CYCLES = WRITE_CYCLES + 3 * PASS_CYCLES;
  // the limit is four times the two runs rounded down to whole thousands
  localparam int MAX_CYCLES = ((2 * RUN_CYCLES * 4) / 1000) * 1000;

  logic                     clk;
  logic                     rst_n;
  logic                     fault_en;
  mem_test_pkg::sram_addr_t fault_addr;
  int                       fault_beat;

  logic                     test_done;
  logic                     test_pass;
  logic [7:0]               debug0;
  logic [7:0]               debug1;
  logic [7:0]               debug2;
  mem_test_pkg::sram_addr_t sram_addr;
  mem_test_pkg::axi_data_t  sram_dq_out;
  mem_test_pkg::axi_data_t  sram_dq_in;
  logic                     sram_dq_oe;
  logic                     sram_we_n;
  logic                     sram_oe_n;
  logic                     sram_ce_n;

  int                       error_count;
  int                       done_count;
  int                       clean_done_count;
  int                       cycle_count;
  logic [31:0]              lcg_state;

  mem_test_top UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .test_done  (test_done),
    .test_pass  (test_pass),
    .debug0     (debug0),
    .debug1     (debug1),
    .debug2     (debug2),
    .sram_addr  (sram_addr),
    .sram_dq_out(sram_dq_out),
    .sram_dq_oe (sram_dq_oe),
    .sram_dq_in (sram_dq_in),
    .sram_we_n  (sram_we_n),
    .sram_oe_n  (sram_oe_n),
    .sram_ce_n  (sram_ce_n)
  );

  sram_model sram_i (
    .addr      (sram_addr),
    .dq_out    (sram_dq_out),
    .dq_oe     (sram_dq_oe),
    .dq_in     (sram_dq_in),
    .ce_n      (sram_ce_n),
    .we_n      (sram_we_n),
    .oe_n      (sram_oe_n),
    .fault_en  (fault_en),
    .fault_addr(fault_addr)
  );

  mem_test_monitor monitor_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .sram_addr  (sram_addr),
    .sram_dq_out(sram_dq_out),
    .sram_dq_oe (sram_dq_oe),
    .sram_we_n  (sram_we_n),
    .sram_oe_n  (sram_oe_n),
    .sram_ce_n  (sram_ce_n),
    .test_done  (test_done),
    .test_pass  (test_pass),
    .debug0     (debug0),
    .debug1     (debug1),
    .debug2     (debug2),
    .fault_en   (fault_en),
    .fault_beat (fault_beat),
    .error_count(error_count),
    .done_count (done_count)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (16) begin
      @(negedge clk);
    end
    rst_n = 1'b1;
  endtask

  task automatic print_summary();
    $display("errors: %0d, test_done pulses: %0d clean run, %0d fault run (beat %0d)",
             error_count, clean_done_count, done_count, fault_beat);
  endtask

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  initial begin
    cycle_count = 0;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      print_summary();
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    rst_n            = 1'b0;
    fault_en         = 1'b0;
    fault_addr       = '0;
    fault_beat       = 0;
    clean_done_count = 0;
    lcg_state        = 32'h7f69;

    // clean run of at least three read passes
    apply_reset();
    while (done_count < 3) begin
      @(negedge clk);
    end
    clean_done_count = done_count;

    // second run with one bad word somewhere in the region
    lcg_state  = lcg_next(lcg_state);
    fault_beat = int'((lcg_state >> 16) % 32'd24);
    @(negedge clk);
    fault_en   = 1'b1;
    fault_addr = mem_test_pkg::sram_addr_t'(5 + fault_beat);
    apply_reset();
    while (test_pass === 1'b1) begin
      @(negedge clk);
    end
    // longer than a read pass, so a stray test_done would show up
    repeat (PASS_CYCLES) begin
      @(negedge clk);
    end

    print_summary();
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- compile.f
mem_test_pkg.sv
axi_sram_ctrl.sv
mem_test_writer.sv
mem_test_reader.sv
mem_test_top.sv
sram_model.sv
mem_test_monitor.sv
tb_mem_test.sv

//--- Makefile
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/Vtb_mem_test: compile.f *.sv
	verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_mem_test -o Vtb_mem_test

run: obj_dir/Vtb_mem_test
	./obj_dir/Vtb_mem_test | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

lint:
	verilator --lint-only -Wall --top-module mem_test_top \
		mem_test_pkg.sv axi_sram_ctrl.sv mem_test_writer.sv mem_test_reader.sv mem_test_top.sv

clean:
	rm -rf obj_dir $(LOG)
